/* Makefile */
VERILATOR ?= verilator
TOP ?= cgra_fabric_tb
RTL_TOP ?= cgra_fabric
FILELIST ?= cgra_fabric.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* cgra_fabric.f */
cgra_pkg.sv
connect_box.sv
switch_box.sv
clb.sv
pe_tile.sv
cgra_fabric.sv
cgra_fabric_tb.sv

/* cgra_fabric.sv */
`timescale 1ns/1ns

module cgra_fabric #(
	parameter int rows = 2,
	parameter int cols = 2
) (
	input logic clk,
	input logic reset,
	input logic config_write,
	input logic [31:0] config_addr,
	input logic [31:0] config_data,
	input logic [4*(rows+cols)-1:0] edge_in,
	output logic [4*(rows+cols)-1:0] edge_out
);

	localparam int nt = cgra_pkg::num_tracks;
	localparam int edge_pad = nt - 2; // Tracks 2 and up stay off the boundary

	localparam int side_n = 0;
	localparam int side_e = 1;
	localparam int side_s = 2;
	localparam int side_w = 3;

	// Edge bit = side base + 2*position + track, position is column or row
	localparam int e_north = 0;
	localparam int e_east = 2 * cols;
	localparam int e_south = 2 * cols + 2 * rows;
	localparam int e_west = 4 * cols + 2 * rows;

	logic [15:0] tile_in [rows][cols];
	logic [15:0] tile_out [rows][cols];

	for (genvar r = 0; r < rows; r++) begin : g_row
		for (genvar c = 0; c < cols; c++) begin : g_col

			if (r > 0) begin : g_n_link
				assign tile_in[r][c][side_n*nt +: nt] = tile_out[r-1][c][side_s*nt +: nt];
			end else begin : g_n_edge
				assign tile_in[r][c][side_n*nt +: nt] =
					{{edge_pad{1'b0}}, edge_in[e_north + 2*c +: 2]};
				assign edge_out[e_north + 2*c +: 2] = tile_out[r][c][side_n*nt +: 2];
			end

			if (c < cols - 1) begin : g_e_link
				assign tile_in[r][c][side_e*nt +: nt] = tile_out[r][c+1][side_w*nt +: nt];
			end else begin : g_e_edge
				assign tile_in[r][c][side_e*nt +: nt] =
					{{edge_pad{1'b0}}, edge_in[e_east + 2*r +: 2]};
				assign edge_out[e_east + 2*r +: 2] = tile_out[r][c][side_e*nt +: 2];
			end

			if (r < rows - 1) begin : g_s_link
				assign tile_in[r][c][side_s*nt +: nt] = tile_out[r+1][c][side_n*nt +: nt];
			end else begin : g_s_edge
				assign tile_in[r][c][side_s*nt +: nt] =
					{{edge_pad{1'b0}}, edge_in[e_south + 2*c +: 2]};
				assign edge_out[e_south + 2*c +: 2] = tile_out[r][c][side_s*nt +: 2];
			end

			if (c > 0) begin : g_w_link
				assign tile_in[r][c][side_w*nt +: nt] = tile_out[r][c-1][side_e*nt +: nt];
			end else begin : g_w_edge
				assign tile_in[r][c][side_w*nt +: nt] =
					{{edge_pad{1'b0}}, edge_in[e_west + 2*r +: 2]};
				assign edge_out[e_west + 2*r +: 2] = tile_out[r][c][side_w*nt +: 2];
			end

			pe_tile #(
				.tile_id(16'(r * cols + c + 1))
			) tile_i (
				.clk(clk),
				.reset(reset),
				.config_write(config_write),
				.config_addr(config_addr),
				.config_data(config_data),
				.track_in(tile_in[r][c]),
				.track_out(tile_out[r][c])
			);
		end
	end

endmodule

/* cgra_fabric_tb.sv */
`timescale 1ns/1ns

module cgra_fabric_tb;

	localparam int num_steps = 17;
	localparam int max_writes = 4;
	localparam int random_vectors = 16;
	localparam int clk_period = 100;
	localparam int edge_side_bits = 4; // Two positions by two tracks per boundary side

	logic clk;
	logic reset;
	logic config_write;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] edge_in;
	logic [15:0] edge_out;

	// Stimulus table, one row per step
	string step_name [num_steps];
	int wr_count [num_steps];
	logic [31:0] wr_addr [num_steps][max_writes];
	logic [31:0] wr_data [num_steps][max_writes];
	logic [15:0] vec_in [num_steps];
	logic [15:0] vec_exp [num_steps];
	bit do_reset [num_steps];
	bit do_random [num_steps];

	integer seed = 32'h4efe_8c29;
	int error_count = 0;
	int check_count = 0;
	int failed_steps = 0;
	longint watchdog_ns = 0;

	cgra_fabric #(
		.rows(2),
		.cols(2)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.config_write(config_write),
		.config_addr(config_addr),
		.config_data(config_data),
		.edge_in(edge_in),
		.edge_out(edge_out)
	);

	always #(clk_period / 2) clk = ~clk;

	// Each boundary output copies the opposite boundary, same position and track
	function automatic logic [15:0] straight_map(input logic [15:0] in_val);
		logic [15:0] result;
		int opp;
		result = '0;
		for (int side = 0; side < 4; side++) begin
			opp = (side + 2) % 4;
			for (int bit_pos = 0; bit_pos < edge_side_bits; bit_pos++) begin
				result[side*edge_side_bits + bit_pos] = in_val[opp*edge_side_bits + bit_pos];
			end
		end
		return result;
	endfunction

	task automatic define_step(input int idx, input string name, input logic [15:0] in_val,
			input logic [15:0] exp_val);
		step_name[idx] = name;
		wr_count[idx] = 0;
		vec_in[idx] = in_val;
		vec_exp[idx] = exp_val;
		do_reset[idx] = 1'b0;
		do_random[idx] = 1'b0;
	endtask

	task automatic add_write(input int idx, input logic [15:0] block, input logic [15:0] tile,
			input logic [31:0] data);
		wr_addr[idx][wr_count[idx]] = {block, tile};
		wr_data[idx][wr_count[idx]] = data;
		wr_count[idx]++;
	endtask

	task automatic load_table();
		// Power-up routing
		define_step(0, "straight after reset", 16'h12a5, 16'ha512);
		define_step(1, "straight after reset", 16'h3c81, 16'h813c);

		// Tile 1 north track 0 turns left onto its west input
		define_step(2, "left turn", 16'h0100, 16'h0000);
		add_write(2, cgra_pkg::cfg_sb, 16'd1, 32'h0000_0001);
		define_step(3, "left turn", 16'h1000, 16'h0011);

		// Tile 4 east track 1 turns right onto its south input
		define_step(4, "right turn", 16'h0800, 16'h0088);
		add_write(4, cgra_pkg::cfg_sb, 16'd4, 32'h0000_0800);
		define_step(5, "right turn", 16'h8000, 16'h0000);

		// Tile 2 combines north track 1 with east track 1 onto north track 0
		define_step(6, "and", 16'h0028, 16'h2804);
		add_write(6, cgra_pkg::cfg_cb0, 16'd2, 32'd1);
		add_write(6, cgra_pkg::cfg_cb1, 16'd2, 32'd1);
		add_write(6, cgra_pkg::cfg_sb, 16'd2, 32'h0000_0003);
		add_write(6, cgra_pkg::cfg_clb, 16'd2, 32'(cgra_pkg::op_and));
		define_step(7, "and", 16'h0408, 16'h0800);
		define_step(8, "or", 16'h0020, 16'h2004);
		add_write(8, cgra_pkg::cfg_clb, 16'd2, 32'(cgra_pkg::op_or));
		define_step(9, "xor", 16'h0008, 16'h0804);
		add_write(9, cgra_pkg::cfg_clb, 16'd2, 32'(cgra_pkg::op_xor));
		define_step(10, "nand", 16'h0028, 16'h2800);
		add_write(10, cgra_pkg::cfg_clb, 16'd2, 32'(cgra_pkg::op_nand));
		// West row 0 track 0 also keeps the tile 1 routes busy
		define_step(11, "nand", 16'h1000, 16'h0015);

		// None of these addresses hits a block
		define_step(12, "unmatched writes", 16'h1000, 16'h0015);
		add_write(12, cgra_pkg::cfg_sb, 16'd9, 32'hffff_ffff);
		add_write(12, 16'd3, 16'd1, 32'hffff_ffff);
		add_write(12, cgra_pkg::cfg_sb, 16'd0, 32'hffff_ffff);
		add_write(12, cgra_pkg::cfg_clb, 16'd5, 32'h0000_0001);

		define_step(13, "random straight", 16'h0000, 16'h0000);
		add_write(13, cgra_pkg::cfg_sb, 16'd1, 32'd0);
		add_write(13, cgra_pkg::cfg_sb, 16'd2, 32'd0);
		add_write(13, cgra_pkg::cfg_sb, 16'd4, 32'd0);
		do_random[13] = 1'b1;

		define_step(14, "custom before reset", 16'h0100, 16'h0000);
		add_write(14, cgra_pkg::cfg_sb, 16'd1, 32'h0000_0001);
		define_step(15, "reset mid-run", 16'h0100, 16'h0001);
		do_reset[15] = 1'b1;
		define_step(16, "straight after reset", 16'h12a5, 16'ha512);
	endtask

	function automatic longint table_cycles();
		longint cycles;
		cycles = 4; // Initial reset
		for (int i = 0; i < num_steps; i++) begin
			cycles += wr_count[i] + 1;
			if (do_random[i]) begin
				cycles += random_vectors;
			end
			if (do_reset[i]) begin
				cycles += 4;
			end
		end
		return cycles;
	endfunction

	task automatic write_config(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		config_write = 1'b1;
		config_addr = addr;
		config_data = data;
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1;
		config_write = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// Ends any pending write, then checks at the falling edge
	task automatic apply_and_check(input int idx, input logic [15:0] in_val,
			input logic [15:0] exp_val);
		@(posedge clk);
		#1;
		config_write = 1'b0;
		config_addr = '0;
		config_data = '0;
		edge_in = in_val;
		@(negedge clk);
		check_count++;
		if (edge_out !== exp_val) begin
			$display("Fail at %0t ns: step %0d edge_in %h expected %h got %h",
				$time, idx, in_val, exp_val, edge_out);
			error_count++;
		end
	endtask

	task automatic run_step(input int idx);
		int errors_before;
		logic [15:0] vec;
		errors_before = error_count;
		if (do_reset[idx]) begin
			pulse_reset();
		end
		for (int w = 0; w < wr_count[idx]; w++) begin
			write_config(wr_addr[idx][w], wr_data[idx][w]);
		end
		if (do_random[idx]) begin
			for (int v = 0; v < random_vectors; v++) begin
				vec = 16'($random(seed));
				apply_and_check(idx, vec, straight_map(vec));
			end
		end else begin
			apply_and_check(idx, vec_in[idx], vec_exp[idx]);
		end
		if (error_count == errors_before) begin
			$display("Step %0d %s: passed", idx, step_name[idx]);
		end else begin
			$display("Step %0d %s: FAILED", idx, step_name[idx]);
			failed_steps++;
		end
	endtask

	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("Run timed out after %0d ns without finishing the table", watchdog_ns);
		$display("Errors found");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		config_write = 1'b0;
		config_addr = '0;
		config_data = '0;
		edge_in = '0;
		load_table();
		watchdog_ns = (table_cycles() + 20) * clk_period;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < num_steps; i++) begin
			run_step(i);
		end
		$display("%0d steps, %0d failed, %0d checks, %0d mismatches",
			num_steps, failed_steps, check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* cgra_pkg.sv */
package cgra_pkg;

	// Tile geometry
	localparam int num_sides = 4; // 0 north, 1 east, 2 south, 3 west
	localparam int num_tracks = 4;

	// Block codes in the upper address half
	localparam logic [15:0] cfg_sb = 16'd7;
	localparam logic [15:0] cfg_cb0 = 16'd6;
	localparam logic [15:0] cfg_cb1 = 16'd5;
	localparam logic [15:0] cfg_clb = 16'd4;

	// Switch box source selects, two bits per output track
	localparam logic [1:0] sel_straight = 2'd0; // Opposite side
	localparam logic [1:0] sel_left = 2'd1; // Side s+3
	localparam logic [1:0] sel_right = 2'd2; // Side s+1
	localparam logic [1:0] sel_pe = 2'd3; // Logic block output

	// Logic block operations
	localparam logic [1:0] op_and = 2'd0;
	localparam logic [1:0] op_or = 2'd1;
	localparam logic [1:0] op_xor = 2'd2;
	localparam logic [1:0] op_nand = 2'd3;

endpackage

/* clb.sv */
`timescale 1ns/1ns

module clb (
	input logic clk,
	input logic reset,
	input logic config_en,
	input logic [1:0] config_data,
	input logic in0,
	input logic in1,
	output logic out
);

	logic [1:0] op;

	always_ff @(posedge clk) begin
		if (reset) begin
			op <= cgra_pkg::op_and;
		end else if (config_en) begin
			op <= config_data;
		end
	end

	// One-bit function of the two connect box operands
	always_comb begin
		case (op)
			cgra_pkg::op_and: out = in0 & in1;
			cgra_pkg::op_or: out = in0 | in1;
			cgra_pkg::op_xor: out = in0 ^ in1;
			cgra_pkg::op_nand: out = ~(in0 & in1);
			default: out = 1'b0;
		endcase
	end

endmodule

/* connect_box.sv */
`timescale 1ns/1ns

module connect_box (
	input logic clk,
	input logic reset,
	input logic config_en,
	input logic [2:0] config_data,
	input logic [7:0] tracks,
	output logic block_out
);

	// Candidates 0-3 are side inputs, 4-7 the same side's outputs
	logic [2:0] sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= 3'd0;
		end else if (config_en) begin
			sel <= config_data;
		end
	end

	assign block_out = tracks[sel];

	// A known select keeps the operand path free of X after reset
	sel_known_a: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(sel)
	) else $error("connect_box select is unknown");

endmodule

/* pe_tile.sv */
`timescale 1ns/1ns

module pe_tile #(
	parameter logic [15:0] tile_id = 16'd1
) (
	input logic clk,
	input logic reset,
	input logic config_write,
	input logic [31:0] config_addr,
	input logic [31:0] config_data,
	input logic [15:0] track_in,
	output logic [15:0] track_out
);

	localparam int nt = cgra_pkg::num_tracks;

	logic id_match;
	logic config_en_sb;
	logic config_en_cb0;
	logic config_en_cb1;
	logic config_en_clb;

	logic op_0;
	logic op_1;
	logic pe_out; // Loops back through the switch box into the connect boxes

	// Low half picks the tile, high half the block
	assign id_match = config_write && (config_addr[15:0] == tile_id);

	assign config_en_sb = id_match && (config_addr[31:16] == cgra_pkg::cfg_sb);
	assign config_en_cb0 = id_match && (config_addr[31:16] == cgra_pkg::cfg_cb0);
	assign config_en_cb1 = id_match && (config_addr[31:16] == cgra_pkg::cfg_cb1);
	assign config_en_clb = id_match && (config_addr[31:16] == cgra_pkg::cfg_clb);

	// North side
	connect_box cb0 (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_cb0),
		.config_data(config_data[2:0]),
		.tracks({track_out[nt-1:0], track_in[nt-1:0]}),
		.block_out(op_0)
	);

	// East side
	connect_box cb1 (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_cb1),
		.config_data(config_data[2:0]),
		.tracks({track_out[2*nt-1:nt], track_in[2*nt-1:nt]}),
		.block_out(op_1)
	);

	switch_box sb (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_sb),
		.config_data(config_data),
		.track_in(track_in),
		.pe_out(pe_out),
		.track_out(track_out)
	);

	clb compute_block (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_clb),
		.config_data(config_data[1:0]),
		.in0(op_0),
		.in1(op_1),
		.out(pe_out)
	);

	// At most one block of this tile takes a given write, and never an unknown one
	cfg_onehot_a: assert property (
		@(posedge clk)
		!$isunknown({config_en_sb, config_en_cb0, config_en_cb1, config_en_clb})
			&& $onehot0({config_en_sb, config_en_cb0, config_en_cb1, config_en_clb})
	) else $error("pe_tile %0d: block enables unknown or more than one set", tile_id);

endmodule

/* switch_box.sv */
`timescale 1ns/1ns

module switch_box (
	input logic clk,
	input logic reset,
	input logic config_en,
	input logic [31:0] config_data,
	input logic [15:0] track_in,
	input logic pe_out,
	output logic [15:0] track_out
);

	localparam int ns = cgra_pkg::num_sides;
	localparam int nt = cgra_pkg::num_tracks;

	// Two select bits per output track, indexed side*4+track
	logic [31:0] sel_cfg;

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_cfg <= '0; // All outputs straight through
		end else if (config_en) begin
			sel_cfg <= config_data;
		end
	end

	for (genvar s = 0; s < ns; s++) begin : g_side
		localparam int s_opp = (s + 2) % ns;
		localparam int s_prev = (s + 3) % ns; // Clockwise-previous
		localparam int s_next = (s + 1) % ns; // Clockwise-next

		for (genvar t = 0; t < nt; t++) begin : g_track
			localparam int idx = s * nt + t;

			logic [1:0] sel;
			logic out_bit;

			assign sel = sel_cfg[2*idx +: 2];

			always_comb begin
				case (sel)
					cgra_pkg::sel_straight: out_bit = track_in[s_opp*nt + t];
					cgra_pkg::sel_left: out_bit = track_in[s_prev*nt + t];
					cgra_pkg::sel_right: out_bit = track_in[s_next*nt + t];
					default: out_bit = pe_out; // sel_pe
				endcase
			end

			assign track_out[idx] = out_bit;
		end
	end

	// Shared config bus must carry real data whenever this box loads
	cfg_data_known_a: assert property (
		@(posedge clk)
		(config_en && !reset) |-> !$isunknown(config_data)
	) else $error("switch_box loaded with unknown config_data");

endmodule
